/* rtl/vca_params.svh */
// Sizing macros for the virtual channel allocator
// Port count, VCs per port, downstream buffer depth and derived widths

`ifndef VCA_PARAMS_SVH
`define VCA_PARAMS_SVH

// Router ports in the order north, east, south, west, local
`define VCA_NUM_PORTS 5

// Virtual channels per port
`define VCA_NUM_VCS 2

// Flits per downstream VC buffer, also the credit count after reset
`define VCA_BUF_DEPTH 4

// Widths of a port index and of a credit count
`define VCA_PORT_W 3
`define VCA_CREDIT_W 3

`endif

/* rtl/vca_pkg.sv */
// Shared vector types of the virtual channel allocator
// Port and VC indices, per-port and per-VC masks, credit counts

`include "vca_params.svh"

package vca_pkg;

	// ==================================================
	// Index types
	// ==================================================

	// 0 north, 1 east, 2 south, 3 west, 4 local
	typedef logic [`VCA_PORT_W-1:0] port_idx_t;

	// Two VCs per port fit in one bit
	typedef logic [0:0] vc_idx_t;

	// ==================================================
	// Mask and count types
	// ==================================================

	// One bit per VC of a port
	typedef logic [`VCA_NUM_VCS-1:0] vc_mask_t;

	// One bit per router port
	typedef logic [`VCA_NUM_PORTS-1:0] port_mask_t;

	// Free slots in one downstream VC buffer
	typedef logic [`VCA_CREDIT_W-1:0] credit_cnt_t;

endpackage

/* rtl/vca_request_decode.sv */
// Request decode stage
// Sorts the valid input requests into one requester mask per output port

`timescale 1ns/1ns

`include "vca_params.svh"

module vca_request_decode
	import vca_pkg::*;
(
	input  port_mask_t req_valid,
	input  port_idx_t  req_out_port [`VCA_NUM_PORTS],
	output port_mask_t req_matrix   [`VCA_NUM_PORTS]
);

	// ==================================================
	// Requester masks
	// ==================================================

	// Bit i of req_matrix[o] set when input i wants output o
	// An index beyond the last port matches no output
	always_comb begin
		for (int o = 0; o < `VCA_NUM_PORTS; o++) begin
			for (int i = 0; i < `VCA_NUM_PORTS; i++) begin
				req_matrix[o][i] = req_valid[i] &&
					(req_out_port[i] == port_idx_t'(o));
			end
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// A valid request must name a real output, else it would wait forever
	for (genvar i = 0; i < `VCA_NUM_PORTS; i++) begin : g_chk
		always_comb begin
			if (req_valid[i]) begin
				port_in_range: assert final (req_out_port[i] < `VCA_NUM_PORTS)
					else $error("input %0d requests output %0d which does not exist",
						i, req_out_port[i]);
			end
		end
	end

endmodule

/* rtl/vca_output_arbiter.sv */
// Round-robin arbiter of one output port
// Picks the next requester after the last grant, gated by output VC credit

`timescale 1ns/1ns

`include "vca_params.svh"

module vca_output_arbiter
	import vca_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  port_mask_t requesters,
	input  vc_idx_t    req_out_vc [`VCA_NUM_PORTS],
	input  vc_mask_t   vc_available,
	output logic       win_valid,
	output port_idx_t  win_port,
	output vc_idx_t    win_vc
);

	// Input that received the last real grant
	port_idx_t last_grant;

	// Round-robin candidate before the credit check
	logic      cand_found;
	port_idx_t cand_port;

	// ==================================================
	// Winner search
	// ==================================================

	// Scan from the input after last_grant, wrapping around,
	// so the last winner has the lowest priority
	always_comb begin
		int unsigned idx;

		cand_found = 1'b0;
		cand_port  = last_grant;
		for (int k = 1; k <= `VCA_NUM_PORTS; k++) begin
			idx = (int'(last_grant) + k) % `VCA_NUM_PORTS;
			if (!cand_found && requesters[idx]) begin
				cand_found = 1'b1;
				cand_port  = port_idx_t'(idx);
			end
		end
	end

	// ==================================================
	// Credit gate
	// ==================================================

	// Output VC the candidate asks for
	assign win_vc   = req_out_vc[cand_port];
	assign win_port = cand_port;

	// No credit on that VC blocks the whole output this cycle,
	// other requesters do not get a second chance
	assign win_valid = cand_found && vc_available[win_vc];

	// ==================================================
	// Round-robin pointer
	// ==================================================

	// Pointer only moves on a grant that really happens
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_grant <= '0;
		end else if (win_valid) begin
			last_grant <= cand_port;
		end
	end

endmodule

/* rtl/vca_credit_counter.sv */
// Downstream credit counters of one output port
// One counter per VC, reports which VCs still have buffer space

`timescale 1ns/1ns

`include "vca_params.svh"

module vca_credit_counter
	import vca_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     consume,
	input  vc_idx_t  consume_vc,
	input  vc_mask_t credit_return,
	output vc_mask_t vc_available
);

	// Free slots per downstream VC buffer
	credit_cnt_t cnt [`VCA_NUM_VCS];

	// ==================================================
	// Per-VC counters
	// ==================================================

	for (genvar v = 0; v < `VCA_NUM_VCS; v++) begin : g_vc
		logic dec;
		logic inc;

		// Grant takes a credit, a returned flit slot gives one back
		assign dec = consume && (consume_vc == vc_idx_t'(v));
		assign inc = credit_return[v];

		// Both in the same cycle cancel out
		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				cnt[v] <= credit_cnt_t'(`VCA_BUF_DEPTH);
			end else if (inc && !dec) begin
				cnt[v] <= cnt[v] + credit_cnt_t'(1);
			end else if (dec && !inc) begin
				cnt[v] <= cnt[v] - credit_cnt_t'(1);
			end
		end

		assign vc_available[v] = (cnt[v] != '0);

		// Arbiter must never grant a VC whose downstream buffer is full
		no_consume_at_zero: assert property (@(posedge clk) disable iff (rst)
			dec |-> cnt[v] != '0)
			else $error("VC %0d consumed with no credit left", v);

		// Downstream cannot free more slots than the buffer holds
		no_return_at_full: assert property (@(posedge clk) disable iff (rst)
			inc |-> cnt[v] != credit_cnt_t'(`VCA_BUF_DEPTH))
			else $error("VC %0d credit returned while counter is full", v);
	end

endmodule

/* rtl/vca_grant_return.sv */
// Grant return stage
// Maps output-side winners back to input ready and one-hot granted VC

`timescale 1ns/1ns

`include "vca_params.svh"

module vca_grant_return
	import vca_pkg::*;
(
	input  port_mask_t req_valid,
	input  vc_idx_t    req_in_vc [`VCA_NUM_PORTS],
	input  port_mask_t win_valid,
	input  port_idx_t  win_port  [`VCA_NUM_PORTS],
	output port_mask_t req_ready,
	output vc_mask_t   grant_vc  [`VCA_NUM_PORTS]
);

	// Bit o of claim[i] set when output o granted input i
	port_mask_t claim [`VCA_NUM_PORTS];

	always_comb begin
		for (int i = 0; i < `VCA_NUM_PORTS; i++) begin
			for (int o = 0; o < `VCA_NUM_PORTS; o++) begin
				claim[i][o] = win_valid[o] && (win_port[o] == port_idx_t'(i));
			end
		end
	end

	// Ready and the input VC that now owns the output VC
	always_comb begin
		for (int i = 0; i < `VCA_NUM_PORTS; i++) begin
			req_ready[i] = |claim[i];
			grant_vc[i]  = req_ready[i] ? (vc_mask_t'(1) << req_in_vc[i]) : '0;
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// An input asks for one output, so at most one arbiter can pick it,
	// and only a valid request can have won
	for (genvar i = 0; i < `VCA_NUM_PORTS; i++) begin : g_chk
		always_comb begin
			if (|claim[i]) begin
				single_claim: assert final ($onehot0(claim[i]))
					else $error("input %0d granted by several outputs", i);
			end
			if (req_ready[i]) begin
				ready_has_valid: assert final (req_valid[i])
					else $error("input %0d ready without a valid request", i);
			end
		end
	end

endmodule

/* rtl/vca_top.sv */
// Virtual channel allocator top level
// Request decode, one arbiter and credit counter per output, grant return

`timescale 1ns/1ns

`include "vca_params.svh"

module vca_top
	import vca_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	// Input side requests, held until ready
	input  port_mask_t req_valid,
	input  port_idx_t  req_out_port  [`VCA_NUM_PORTS],
	input  vc_idx_t    req_out_vc    [`VCA_NUM_PORTS],
	input  vc_idx_t    req_in_vc     [`VCA_NUM_PORTS],

	// Credits coming back from downstream routers
	input  vc_mask_t   credit_return [`VCA_NUM_PORTS],

	output port_mask_t req_ready,
	output vc_mask_t   grant_vc      [`VCA_NUM_PORTS],
	output vc_mask_t   vc_available  [`VCA_NUM_PORTS]
);

	// Requester mask per output port
	port_mask_t req_matrix [`VCA_NUM_PORTS];

	// Winner of each output port
	port_mask_t win_valid;
	port_idx_t  win_port   [`VCA_NUM_PORTS];
	vc_idx_t    win_vc     [`VCA_NUM_PORTS];

	// ==================================================
	// Stage 1 request decode
	// ==================================================

	vca_request_decode u_decode (
		.req_valid    (req_valid),
		.req_out_port (req_out_port),
		.req_matrix   (req_matrix)
	);

	// ==================================================
	// Stage 2 arbitration and credits per output
	// ==================================================

	for (genvar o = 0; o < `VCA_NUM_PORTS; o++) begin : g_out
		vca_output_arbiter u_arb (
			.clk          (clk),
			.rst          (rst),
			.requesters   (req_matrix[o]),
			.req_out_vc   (req_out_vc),
			.vc_available (vc_available[o]),
			.win_valid    (win_valid[o]),
			.win_port     (win_port[o]),
			.win_vc       (win_vc[o])
		);

		// Counter sees the grant in the same cycle, so availability
		// drops at the next edge
		vca_credit_counter u_credit (
			.clk           (clk),
			.rst           (rst),
			.consume       (win_valid[o]),
			.consume_vc    (win_vc[o]),
			.credit_return (credit_return[o]),
			.vc_available  (vc_available[o])
		);
	end

	// ==================================================
	// Stage 3 grant return
	// ==================================================

	vca_grant_return u_grant (
		.req_valid (req_valid),
		.req_in_vc (req_in_vc),
		.win_valid (win_valid),
		.win_port  (win_port),
		.req_ready (req_ready),
		.grant_vc  (grant_vc)
	);

endmodule

/* testbench/vca_tb.sv */
// Testbench of the virtual channel allocator
// Stimulus table with hand-worked expected values, compare tasks, watchdog

`timescale 1ns/1ns

`include "vca_params.svh"

module vca_tb
	import vca_pkg::*;
();

	localparam int NP           = `VCA_NUM_PORTS;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS     = 20;
	localparam int CLK_PERIOD   = 40;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_ROWS + 10) * CLK_PERIOD;

	// Router port numbers
	localparam int NORTH = 0;
	localparam int EAST  = 1;
	localparam int SOUTH = 2;
	localparam int WEST  = 3;
	localparam int LOCAL = 4;

	logic       clk;
	logic       rst;
	port_mask_t req_valid;
	port_idx_t  req_out_port  [NP];
	vc_idx_t    req_out_vc    [NP];
	vc_idx_t    req_in_vc     [NP];
	vc_mask_t   credit_return [NP];
	port_mask_t req_ready;
	vc_mask_t   grant_vc      [NP];
	vc_mask_t   vc_available  [NP];

	// Stimulus and expected values, one entry per cycle
	port_mask_t t_valid     [NUM_ROWS];
	port_idx_t  t_port      [NUM_ROWS][NP];
	vc_idx_t    t_ovc       [NUM_ROWS][NP];
	vc_idx_t    t_ivc       [NUM_ROWS][NP];
	vc_mask_t   t_cred      [NUM_ROWS][NP];
	port_mask_t t_exp_ready [NUM_ROWS];
	vc_mask_t   t_exp_grant [NUM_ROWS][NP];
	vc_mask_t   t_exp_avail [NUM_ROWS][NP];
	int         nrows;
	int         cur_row;

	vca_top dut0 (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req_out_port  (req_out_port),
		.req_out_vc    (req_out_vc),
		.req_in_vc     (req_in_vc),
		.credit_return (credit_return),
		.req_ready     (req_ready),
		.grant_vc      (grant_vc),
		.vc_available  (vc_available)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==================================================
	// Table building
	// ==================================================

	// New row, idle by default, availability carried over from the row before
	task automatic start_row();
		int p;
		cur_row = nrows;
		nrows = nrows + 1;
		t_valid[cur_row] = '0;
		t_exp_ready[cur_row] = '0;
		for (p = 0; p < NP; p++) begin
			t_port[cur_row][p] = '0;
			t_ovc[cur_row][p] = '0;
			t_ivc[cur_row][p] = '0;
			t_cred[cur_row][p] = '0;
			t_exp_grant[cur_row][p] = '0;
			if (cur_row == 0) begin
				t_exp_avail[cur_row][p] = '1;
			end else begin
				t_exp_avail[cur_row][p] = t_exp_avail[cur_row - 1][p];
			end
		end
	endtask

	task automatic add_request(input int in_port, input int out_port,
		input int out_vc, input int in_vc);
		t_valid[cur_row][in_port] = 1'b1;
		t_port[cur_row][in_port] = port_idx_t'(out_port);
		t_ovc[cur_row][in_port] = vc_idx_t'(out_vc);
		t_ivc[cur_row][in_port] = vc_idx_t'(in_vc);
	endtask

	task automatic add_credit(input int out_port, input vc_mask_t mask);
		t_cred[cur_row][out_port] = mask;
	endtask

	task automatic expect_grant(input int in_port, input vc_mask_t mask);
		t_exp_ready[cur_row][in_port] = 1'b1;
		t_exp_grant[cur_row][in_port] = mask;
	endtask

	task automatic expect_avail(input int out_port, input vc_mask_t mask);
		t_exp_avail[cur_row][out_port] = mask;
	endtask

	task automatic build_table();
		// Idle right after reset
		start_row();
		// Lone request east to south VC0, granted at once
		start_row();
		add_request(EAST, SOUTH, 0, 1);
		expect_grant(EAST, 2'b10);
		start_row();
		// Three holders for west VC1, rotation starts after north
		start_row();
		add_request(NORTH, WEST, 1, 0);
		add_request(SOUTH, WEST, 1, 1);
		add_request(LOCAL, WEST, 1, 0);
		expect_grant(SOUTH, 2'b10);
		start_row();
		add_request(NORTH, WEST, 1, 0);
		add_request(LOCAL, WEST, 1, 0);
		expect_grant(LOCAL, 2'b01);
		start_row();
		add_request(NORTH, WEST, 1, 0);
		expect_grant(NORTH, 2'b01);
		// Four grants drain north VC0
		start_row();
		add_request(EAST, NORTH, 0, 0);
		expect_grant(EAST, 2'b01);
		start_row();
		add_request(WEST, NORTH, 0, 1);
		expect_grant(WEST, 2'b10);
		start_row();
		add_request(EAST, NORTH, 0, 1);
		expect_grant(EAST, 2'b10);
		start_row();
		add_request(WEST, NORTH, 0, 0);
		expect_grant(WEST, 2'b01);
		// Fifth request waits while one credit comes back
		start_row();
		add_request(LOCAL, NORTH, 0, 1);
		add_credit(NORTH, 2'b01);
		expect_avail(NORTH, 2'b10);
		start_row();
		add_request(LOCAL, NORTH, 0, 1);
		expect_avail(NORTH, 2'b11);
		expect_grant(LOCAL, 2'b10);
		// Round-robin pick has no credit, south on VC1 must wait too
		start_row();
		add_request(NORTH, NORTH, 0, 1);
		add_request(SOUTH, NORTH, 1, 0);
		expect_avail(NORTH, 2'b10);
		start_row();
		add_request(NORTH, NORTH, 0, 1);
		add_request(SOUTH, NORTH, 1, 0);
		add_credit(NORTH, 2'b01);
		start_row();
		add_request(NORTH, NORTH, 0, 1);
		add_request(SOUTH, NORTH, 1, 0);
		expect_avail(NORTH, 2'b11);
		expect_grant(NORTH, 2'b10);
		start_row();
		add_request(SOUTH, NORTH, 1, 0);
		expect_avail(NORTH, 2'b10);
		expect_grant(SOUTH, 2'b01);
		// West VC1 holds one credit, grant and return cancel out
		start_row();
		add_request(EAST, WEST, 1, 1);
		add_request(NORTH, LOCAL, 0, 0);
		add_credit(WEST, 2'b10);
		expect_grant(EAST, 2'b10);
		expect_grant(NORTH, 2'b01);
		start_row();
		// Last credit of west VC1 goes
		start_row();
		add_request(SOUTH, WEST, 1, 1);
		expect_grant(SOUTH, 2'b10);
		start_row();
		expect_avail(WEST, 2'b01);
	endtask

	// ==================================================
	// Drive and compare
	// ==================================================

	task automatic apply_row(input int row);
		int p;
		req_valid <= t_valid[row];
		for (p = 0; p < NP; p++) begin
			req_out_port[p] <= t_port[row][p];
			req_out_vc[p] <= t_ovc[row][p];
			req_in_vc[p] <= t_ivc[row][p];
			credit_return[p] <= t_cred[row][p];
		end
	endtask

	task automatic check_ready(input int row, input port_mask_t got, input port_mask_t exp);
		if (got !== exp) begin
			$display("FAILED req_ready row %0d got %h expected %h", row, got, exp);
			$display("sim failed");
			$fatal(1, "req_ready mismatch");
		end
	endtask

	task automatic check_grant(input int row, input int p, input vc_mask_t got,
		input vc_mask_t exp);
		if (got !== exp) begin
			$display("FAILED grant_vc[%0d] row %0d got %h expected %h", p, row, got, exp);
			$display("sim failed");
			$fatal(1, "grant_vc mismatch");
		end
	endtask

	task automatic check_avail(input int row, input int p, input vc_mask_t got,
		input vc_mask_t exp);
		if (got !== exp) begin
			$display("FAILED vc_available[%0d] row %0d got %h expected %h",
				p, row, got, exp);
			$display("sim failed");
			$fatal(1, "vc_available mismatch");
		end
	endtask

	task automatic check_row(input int row);
		int p;
		check_ready(row, req_ready, t_exp_ready[row]);
		for (p = 0; p < NP; p++) begin
			check_grant(row, p, grant_vc[p], t_exp_grant[row][p]);
			check_avail(row, p, vc_available[p], t_exp_avail[row][p]);
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req_valid = '0;
		for (int p = 0; p < NP; p++) begin
			req_out_port[p] = '0;
			req_out_vc[p] = '0;
			req_in_vc[p] = '0;
			credit_return[p] = '0;
		end
		nrows = 0;
		cur_row = 0;
		build_table();
		if (nrows != NUM_ROWS) begin
			$display("stimulus table holds %0d rows instead of %0d", nrows, NUM_ROWS);
			$display("sim failed");
			$fatal(1, "bad table length");
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int k = 0; k < NUM_ROWS; k++) begin
			@(posedge clk);
			apply_row(k);
			// Outputs settled half a period after the drive
			@(negedge clk);
			check_row(k);
		end
		$display("sim passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out before the stimulus table finished");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* src.f */
+incdir+rtl
rtl/vca_pkg.sv
rtl/vca_request_decode.sv
rtl/vca_output_arbiter.sv
rtl/vca_credit_counter.sv
rtl/vca_grant_return.sv
rtl/vca_top.sv
testbench/vca_tb.sv
